// File: tb.f
+incdir+source
source/serial_bus_pkg.sv
source/bit_serdes.sv
source/slave_mem.sv
source/bus_slave.sv
source/bus_master.sv
source/serial_bus_top.sv
verification/serial_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the serial bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module serial_bus_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// File: verification/serial_bus_tb.sv
// clock, reset, LFSR, reference model, directed tests and watchdog for the serial bus testbench
`timescale 1ns/1ns
`default_nettype none
`include "serial_bus_consts.svh"

module serial_bus_tb;
    localparam int n_trans    = 51; // 4 + 4 + 2 + 1 + 40
    localparam int max_cycles = 8 + 20 + n_trans * (`SB_ACK_TIMEOUT + `SB_RSP_TIMEOUT + 60);
    localparam int no_ack_lim = `SB_ACK_TIMEOUT + 40;

    logic                      clk;
    logic                      rstn;
    logic                      req_valid;
    logic                      req_ready;
    serial_bus_pkg::host_req_t req;
    logic                      rsp_valid;
    logic                      rsp_ready;
    serial_bus_pkg::host_rsp_t rsp;

    logic [31:0]               lfsr;
    int                        errors;
    logic [`SB_DATA_W-1:0]     ref_mem [2**`SB_ID_W][2**`SB_ADDR_W]; // by slave id
    bit                        written [2**`SB_ID_W][2**`SB_ADDR_W];

    serial_bus_top i_serial_bus_top (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic send_req(input logic wr, input logic [`SB_ID_W-1:0] id,
                            input logic [`SB_ADDR_W-1:0] addr,
                            input logic [`SB_DATA_W-1:0] data);
        req_valid = 1'b1;
        req.wr    = wr;
        req.id    = id;
        req.addr  = addr;
        req.wdata = data;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1 req_valid = 1'b0;
    endtask

    task automatic get_rsp(output serial_bus_pkg::host_rsp_t r);
        @(negedge clk);
        while (!rsp_valid) @(negedge clk);
        r = rsp;
        @(posedge clk); // taken here as rsp_ready is high
        #1;
    endtask

    task automatic write_word(input logic [`SB_ID_W-1:0] id, input logic [`SB_ADDR_W-1:0] addr,
                              input logic [`SB_DATA_W-1:0] data);
        serial_bus_pkg::host_rsp_t r;
        send_req(1'b1, id, addr, data);
        get_rsp(r);
        if (r.no_ack !== 1'b0) begin
            $display("error: rsp.no_ack got %h expected 0 (write id %h addr %h)",
                     r.no_ack, id, addr);
            errors++;
        end
        ref_mem[id][addr] = data;
        written[id][addr] = 1'b1;
    endtask

    task automatic read_word(input logic [`SB_ID_W-1:0] id, input logic [`SB_ADDR_W-1:0] addr);
        serial_bus_pkg::host_rsp_t r;
        send_req(1'b0, id, addr, '0);
        get_rsp(r);
        if (r.no_ack !== 1'b0) begin
            $display("error: rsp.no_ack got %h expected 0 (read id %h addr %h)",
                     r.no_ack, id, addr);
            errors++;
        end
        if (r.rdata !== ref_mem[id][addr]) begin
            $display("error: rsp.rdata got %h expected %h (id %h addr %h)",
                     r.rdata, ref_mem[id][addr], id, addr);
            errors++;
        end
    endtask

    task automatic reset_values();
        @(negedge clk);
        if (rsp_valid !== 1'b0) begin
            $display("error: rsp_valid got %h expected 0 after reset", rsp_valid);
            errors++;
        end
        if (req_ready !== 1'b1) begin
            $display("error: req_ready got %h expected 1 after reset", req_ready);
            errors++;
        end
        if (i_serial_bus_top.bus_line !== 1'b1) begin
            $display("error: bus_line got %h expected 1 after reset", i_serial_bus_top.bus_line);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic round_trip();
        write_word(`SB_ID_W'(1), 8'h3c, 8'ha5);
        read_word(`SB_ID_W'(1), 8'h3c);
        write_word(`SB_ID_W'(2), 8'h10, 8'h5a); // latency 4 slave
        read_word(`SB_ID_W'(2), 8'h10);
    endtask

    task automatic id_decode();
        write_word(`SB_ID_W'(1), 8'h77, 8'h11);
        write_word(`SB_ID_W'(2), 8'h77, 8'hee);
        read_word(`SB_ID_W'(1), 8'h77);
        read_word(`SB_ID_W'(2), 8'h77);
    endtask

    task automatic absent_slave();
        serial_bus_pkg::host_rsp_t r;
        int                        cycles;
        send_req(1'b1, `SB_ID_W'(5), 8'h20, 8'h99);
        cycles = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles > no_ack_lim) begin
            $display("the response for id 5 came %0d cycles after acceptance, limit %0d",
                     cycles, no_ack_lim);
            errors++;
        end
        r = rsp;
        @(posedge clk); // taken here as rsp_ready is high
        #1;
        if (r.no_ack !== 1'b1) begin
            $display("error: rsp.no_ack got %h expected 1 for id 5", r.no_ack);
            errors++;
        end
        read_word(`SB_ID_W'(1), 8'h3c); // bus must be idle again
    endtask

    task automatic stalled_response();
        serial_bus_pkg::host_rsp_t held;
        rsp_ready = 1'b0;
        send_req(1'b0, `SB_ID_W'(2), 8'h10, '0);
        @(negedge clk);
        while (!rsp_valid) @(negedge clk);
        held = rsp;
        repeat (20) begin
            @(negedge clk);
            if (rsp_valid !== 1'b1) begin
                $display("error: rsp_valid got %h expected 1 while stalled", rsp_valid);
                errors++;
            end
            if (rsp !== held) begin
                $display("error: rsp got %h expected %h while stalled", rsp, held);
                errors++;
            end
            if (req_ready !== 1'b0) begin
                $display("error: req_ready got %h expected 0 while stalled", req_ready);
                errors++;
            end
        end
        @(posedge clk);
        #1 rsp_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (rsp_valid !== 1'b0 || req_ready !== 1'b1) begin
            $display("error: rsp_valid %h req_ready %h expected 0 and 1 after take",
                     rsp_valid, req_ready);
            errors++;
        end
        if (held.no_ack !== 1'b0 || held.rdata !== ref_mem[2][8'h10]) begin
            $display("error: rsp got %h expected %h after stall", held, {ref_mem[2][8'h10], 1'b0});
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic random_traffic();
        logic [31:0]           rnd_wr;
        logic [31:0]           rnd_id;
        logic [31:0]           rnd_addr;
        logic [31:0]           rnd_data;
        logic [`SB_ID_W-1:0]   id;
        logic [`SB_ADDR_W-1:0] addr;
        for (int i = 0; i < 40; i++) begin
            take_bits(1, rnd_wr);
            take_bits(1, rnd_id);
            take_bits(4, rnd_addr); // small window so later reads land on written words
            take_bits(`SB_DATA_W, rnd_data);
            id   = rnd_id[0] ? `SB_ID_W'(2) : `SB_ID_W'(1);
            addr = rnd_addr[`SB_ADDR_W-1:0];
            if (rnd_wr[0] || !written[id][addr])
                write_word(id, addr, rnd_data[`SB_DATA_W-1:0]); // unwritten reads become writes
            else
                read_word(id, addr);
        end
    endtask

    initial begin
        lfsr      = 32'h36b1;
        errors    = 0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1 rstn = 1'b1;
        reset_values();
        round_trip();
        id_decode();
        absent_slave();
        stalled_response();
        random_traffic();
        $display("checks failed: %0d", errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/serial_bus_top.sv
// serial_bus_top: master, two slaves with memories, wired-AND line
`timescale 1ns/1ns
`default_nettype none
`include "serial_bus_consts.svh"

module serial_bus_top (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             req_valid,
    output logic                            req_ready,
    input  wire serial_bus_pkg::host_req_t  req,
    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output serial_bus_pkg::host_rsp_t       rsp
);
    logic                       master_line;
    logic [1:0]                 slave_line;
    logic                       bus_line;
    serial_bus_pkg::bus_ctrl_t  bus_ctrl;
    logic [1:0]                 mem_wr;
    logic [1:0]                 mem_rd;
    logic [1:0]                 mem_done;
    logic [`SB_ADDR_W-1:0]      mem_addr  [2];
    logic [`SB_DATA_W-1:0]      mem_wdata [2];
    logic [`SB_DATA_W-1:0]      mem_rdata [2];

    assign bus_line = master_line & (&slave_line); // open drain resolution

    bus_master i_bus_master (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .bus_line    (bus_line),
        .master_line (master_line),
        .bus_ctrl    (bus_ctrl)
    );

    // slave ids 1 and 2
    for (genvar i = 0; i < 2; i++) begin : g_slave
        bus_slave #(
            .self_id (`SB_ID_W'(i + 1))
        ) i_bus_slave (
            .clk        (clk),
            .rstn       (rstn),
            .bus_line   (bus_line),
            .bus_ctrl   (bus_ctrl),
            .slave_line (slave_line[i]),
            .mem_wr     (mem_wr[i]),
            .mem_rd     (mem_rd[i]),
            .mem_addr   (mem_addr[i]),
            .mem_wdata  (mem_wdata[i]),
            .mem_done   (mem_done[i]),
            .mem_rdata  (mem_rdata[i])
        );

        slave_mem #(
            .lat ((i == 0) ? `SB_LAT_S1 : `SB_LAT_S2)
        ) i_slave_mem (
            .clk       (clk),
            .rstn      (rstn),
            .mem_wr    (mem_wr[i]),
            .mem_rd    (mem_rd[i]),
            .mem_addr  (mem_addr[i]),
            .mem_wdata (mem_wdata[i]),
            .mem_done  (mem_done[i]),
            .mem_rdata (mem_rdata[i])
        );
    end

endmodule

`default_nettype wire

// File: source/bus_master.sv
// bus_master: host request framing, slave timeouts and host response
`timescale 1ns/1ns
`default_nettype none
`include "serial_bus_consts.svh"

module bus_master (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             req_valid,
    output logic                            req_ready,
    input  wire serial_bus_pkg::host_req_t  req,
    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output serial_bus_pkg::host_rsp_t       rsp,
    input  wire                             bus_line,
    output logic                            master_line,
    output serial_bus_pkg::bus_ctrl_t       bus_ctrl
);
    // leading zero of the word is the second start bit
    localparam int frame_w = 1 + `SB_ID_W + `SB_ADDR_W;
    localparam int cnt_w   = $clog2(frame_w + 1);
    localparam int wait_w  = $clog2(`SB_ACK_TIMEOUT + `SB_RSP_TIMEOUT);

    typedef enum logic [3:0] {
        st_idle,
        st_frame,
        st_ack_wait,
        st_ack_end,
        st_wr_data,
        st_turn_wr,
        st_rd,
        st_util,
        st_rsp
    } state_t;

    state_t                     state;
    serial_bus_pkg::host_req_t  req_q;
    logic [wait_w-1:0]          wait_cnt;
    logic                       accept;
    logic                       ack_lost;
    logic                       data_ok;
    logic                       data_lost;
    logic                       tx_start;
    logic                       tx_done;
    logic                       rx_valid;
    logic [cnt_w-1:0]           bit_count;
    logic [frame_w-1:0]         tx_word;
    logic [frame_w-1:0]         rx_word;

    assign req_ready = (state == st_idle);
    assign rsp_valid = (state == st_rsp);
    assign accept    = req_valid && req_ready;

    assign ack_lost  = (state == st_ack_wait) && bus_line
                       && (wait_cnt == wait_w'(`SB_ACK_TIMEOUT - 1));
    assign data_ok   = ((state == st_turn_wr) && !bus_line) || ((state == st_rd) && rx_valid);
    assign data_lost = ((state == st_turn_wr) || (state == st_rd)) && !data_ok
                       && (wait_cnt == wait_w'(`SB_RSP_TIMEOUT - 1));

    assign tx_start  = accept || ((state == st_ack_end) && bus_line && req_q.wr);
    assign bit_count = (state == st_idle) ? cnt_w'(frame_w) : cnt_w'(`SB_DATA_W);
    assign tx_word   = (state == st_idle) ? {1'b0, req.id, req.addr}
                                          : {{(frame_w - `SB_DATA_W){1'b0}}, req_q.wdata};

    assign bus_ctrl.rd_wrt   = req_q.wr;
    assign bus_ctrl.bus_util = (state == st_util);
    assign bus_ctrl.turn     = (state == st_turn_wr) || (state == st_rd);

    bit_serdes #(
        .max_bits (frame_w)
    ) i_bit_serdes (
        .clk       (clk),
        .rstn      (rstn),
        .tx_start  (tx_start),
        .rx_en     (state == st_rd),
        .bit_count (bit_count),
        .tx_word   (tx_word),
        .line_in   (bus_line),
        .line_out  (master_line),
        .tx_done   (tx_done),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            wait_cnt <= '0;
        end else begin
            case (state)
                st_idle:  if (accept) state <= st_frame;
                st_frame: begin
                    wait_cnt <= '0;
                    if (tx_done) state <= st_ack_wait;
                end
                st_ack_wait: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (!bus_line)
                        state <= st_ack_end;
                    else if (ack_lost)
                        state <= st_util;
                end
                st_ack_end: begin
                    wait_cnt <= '0;
                    if (bus_line) state <= req_q.wr ? st_wr_data : st_rd; // ack over
                end
                st_wr_data: begin
                    wait_cnt <= '0;
                    if (tx_done) state <= st_turn_wr;
                end
                st_turn_wr, st_rd: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (data_ok || data_lost) state <= st_util;
                end
                st_util: state <= st_rsp;
                st_rsp:  if (rsp_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
            rsp   <= '0;
        end
        if (ack_lost || data_lost)
            rsp.no_ack <= 1'b1;
        if (state == st_rd && rx_valid)
            rsp.rdata <= rx_word[`SB_DATA_W-1:0];
    end

endmodule

`default_nettype wire

// File: source/bus_slave.sv
// bus_slave: frame decoder and response FSM for one slave id
`timescale 1ns/1ns
`default_nettype none
`include "serial_bus_consts.svh"

module bus_slave #(
    parameter logic [`SB_ID_W-1:0] self_id = 1
) (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        bus_line,
    input  wire serial_bus_pkg::bus_ctrl_t bus_ctrl,
    output logic                       slave_line,
    output logic                       mem_wr,
    output logic                       mem_rd,
    output logic [`SB_ADDR_W-1:0]      mem_addr,
    output logic [`SB_DATA_W-1:0]      mem_wdata,
    input  wire                        mem_done,
    input  wire  [`SB_DATA_W-1:0]      mem_rdata
);
    localparam int frame_w = `SB_ID_W + `SB_ADDR_W;
    localparam int cnt_w   = $clog2(frame_w + 1);

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_addr_rx,
        st_wait_peer,
        st_ack,
        st_data_rx,
        st_mem_busy,
        st_wait_turn,
        st_done,
        st_data_tx
    } state_t;

    state_t               state;
    logic                 pull;
    logic                 ack_cnt;
    logic                 ser_line;
    logic                 tx_start;
    logic                 rx_en;
    logic                 tx_done;
    logic                 rx_valid;
    logic [cnt_w-1:0]     bit_count;
    logic [frame_w-1:0]   tx_word;
    logic [frame_w-1:0]   rx_word;

    // second start bit arms the receiver for id and address
    assign rx_en     = (state == st_start) || (state == st_data_rx);
    assign tx_start  = (state == st_wait_turn) && bus_ctrl.turn && !bus_ctrl.rd_wrt
                       && !bus_ctrl.bus_util;
    assign bit_count = (state == st_start) ? cnt_w'(frame_w) : cnt_w'(`SB_DATA_W);
    assign tx_word   = {{(frame_w - `SB_DATA_W){1'b0}}, mem_rdata};
    assign slave_line = ser_line & ~pull; // open drain

    bit_serdes #(
        .max_bits (frame_w)
    ) i_bit_serdes (
        .clk       (clk),
        .rstn      (rstn),
        .tx_start  (tx_start),
        .rx_en     (rx_en),
        .bit_count (bit_count),
        .tx_word   (tx_word),
        .line_in   (bus_line),
        .line_out  (ser_line),
        .tx_done   (tx_done),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= st_idle;
            pull    <= 1'b0;
            ack_cnt <= 1'b0;
            mem_wr  <= 1'b0;
            mem_rd  <= 1'b0;
        end else begin
            mem_wr <= 1'b0;
            mem_rd <= 1'b0;
            if (bus_ctrl.bus_util) begin
                state <= st_idle;
                pull  <= 1'b0;
            end else begin
                case (state)
                    st_idle:  if (!bus_line) state <= st_start;
                    st_start: state <= bus_line ? st_wait_peer : st_addr_rx;
                    st_addr_rx: begin
                        if (rx_valid) begin
                            if (rx_word[frame_w-1 -: `SB_ID_W] == self_id) begin
                                pull    <= 1'b1; // acknowledge
                                ack_cnt <= 1'b0;
                                state   <= st_ack;
                            end else begin
                                state <= st_wait_peer;
                            end
                        end
                    end
                    st_ack: begin
                        ack_cnt <= 1'b1;
                        if (ack_cnt) begin
                            pull <= 1'b0;
                            if (bus_ctrl.rd_wrt) begin
                                state <= st_data_rx;
                            end else begin
                                mem_rd <= 1'b1;
                                state  <= st_mem_busy;
                            end
                        end
                    end
                    st_data_rx: begin
                        if (rx_valid) begin
                            mem_wr <= 1'b1;
                            state  <= st_mem_busy;
                        end
                    end
                    st_mem_busy: if (mem_done) state <= st_wait_turn;
                    st_wait_turn: begin
                        if (bus_ctrl.turn) begin
                            if (bus_ctrl.rd_wrt) begin
                                pull  <= 1'b1; // write done pulse
                                state <= st_done;
                            end else begin
                                state <= st_data_tx;
                            end
                        end
                    end
                    st_done: begin
                        pull  <= 1'b0;
                        state <= st_wait_peer;
                    end
                    st_data_tx: if (tx_done) state <= st_wait_peer;
                    default: ; // st_wait_peer leaves only on bus_util
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_addr_rx && rx_valid)
            mem_addr <= rx_word[`SB_ADDR_W-1:0];
        if (state == st_data_rx && rx_valid)
            mem_wdata <= rx_word[`SB_DATA_W-1:0];
    end

endmodule

`default_nettype wire

// File: source/slave_mem.sv
// slave_mem: local word memory with fixed access latency
`timescale 1ns/1ns
`default_nettype none
`include "serial_bus_consts.svh"

module slave_mem #(
    parameter int lat = 1
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    mem_wr,
    input  wire                    mem_rd,
    input  wire  [`SB_ADDR_W-1:0]  mem_addr,
    input  wire  [`SB_DATA_W-1:0]  mem_wdata,
    output logic                   mem_done,
    output logic [`SB_DATA_W-1:0]  mem_rdata
);
    localparam int cnt_w = $clog2(lat + 1);

    logic [`SB_DATA_W-1:0] mem [2**`SB_ADDR_W];
    logic [cnt_w-1:0]      lat_cnt;

    // done comes exactly lat cycles after the strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lat_cnt  <= '0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (mem_wr || mem_rd) begin
                lat_cnt  <= cnt_w'(lat - 1);
                mem_done <= (lat == 1);
            end else if (lat_cnt != '0) begin
                lat_cnt  <= lat_cnt - 1'b1;
                mem_done <= (lat_cnt == cnt_w'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr)
            mem[mem_addr] <= mem_wdata;
        if (mem_rd)
            mem_rdata <= mem[mem_addr]; // held until the next read
    end

endmodule

`default_nettype wire

// File: source/bit_serdes.sv
// bit_serdes: start-bit framed shifter for the serial line
`timescale 1ns/1ns
`default_nettype none

module bit_serdes #(
    parameter int max_bits = 12
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              tx_start,
    input  wire                              rx_en,
    input  wire  [$clog2(max_bits + 1)-1:0]  bit_count,
    input  wire  [max_bits-1:0]              tx_word,
    input  wire                              line_in,
    output logic                             line_out,
    output logic                             tx_done,
    output logic                             rx_valid,
    output logic [max_bits-1:0]              rx_word
);
    localparam int cnt_w = $clog2(max_bits + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_tx,
        st_rx
    } state_t;

    state_t              state;
    logic [max_bits-1:0] shreg;
    logic [cnt_w-1:0]    cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            cnt      <= '0;
            line_out <= 1'b1;
            tx_done  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            tx_done  <= 1'b0;
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= bit_count;
                    if (tx_start) begin
                        line_out <= 1'b0; // start bit
                        state    <= st_tx;
                    end else if (rx_en && !line_in) begin
                        state <= st_rx;
                    end
                end
                st_tx: begin
                    if (cnt != '0) begin
                        line_out <= shreg[cnt - 1'b1]; // msb first
                        cnt      <= cnt - 1'b1;
                    end else begin
                        line_out <= 1'b1;
                        tx_done  <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_rx: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == cnt_w'(1)) begin
                        rx_valid <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // tx reads the word by index, rx shifts in from the lsb
    always_ff @(posedge clk) begin
        if (state == st_idle && tx_start)
            shreg <= tx_word;
        else if (state == st_rx)
            shreg <= {shreg[max_bits-2:0], line_in};
    end

    assign rx_word = shreg;

endmodule

`default_nettype wire

// File: source/serial_bus_pkg.sv
// host request, host response and bus sideband types
`default_nettype none
`include "serial_bus_consts.svh"

package serial_bus_pkg;

    typedef struct packed {
        logic                  wr;     // 1 = write
        logic [`SB_ID_W-1:0]   id;
        logic [`SB_ADDR_W-1:0] addr;
        logic [`SB_DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [`SB_DATA_W-1:0] rdata;
        logic                  no_ack; // slave absent or data phase lost
    } host_rsp_t;

    // master to all slaves, beside the line
    typedef struct packed {
        logic rd_wrt;   // 1 = write
        logic bus_util; // line free, slaves go idle
        logic turn;     // master released the line and listens
    } bus_ctrl_t;

endpackage

`default_nettype wire

// File: source/serial_bus_consts.svh
// bus widths, master timeouts and slave memory latencies
`ifndef SERIAL_BUS_CONSTS_SVH
`define SERIAL_BUS_CONSTS_SVH

`define SB_ADDR_W 8
`define SB_DATA_W 8
`define SB_ID_W 3

// cycles the master waits for an acknowledge
`define SB_ACK_TIMEOUT 16
// cycles the master waits for the data phase once the turn is given
`define SB_RSP_TIMEOUT 64

`define SB_LAT_S1 1
`define SB_LAT_S2 4

`endif
